/* sim.f */
source/csr_pkg.sv
source/fcsr_file.sv
source/core_info_csrs.sv
source/csr_apb_slave.sv
source/csr_unit.sv
testbench/tb_csr_unit.sv

/* run_sim.sh */
#!/bin/sh
# Builds the CSR block testbench with Verilator and runs it.
# Exit status is nonzero when a step fails or the log reports a failure.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --timescale 1ns/1ns \
    --top-module tb_csr_unit -f sim.f -o tb_csr_unit > "$BUILD_LOG" 2>&1
status=$?
cat "$BUILD_LOG"
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_csr_unit > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" "$SIM_LOG"; then
    echo "Failure reported in $SIM_LOG"
    exit 1
fi

exit 0

/* testbench/tb_csr_unit.sv */
//////////////////////////////////////////////////
// Random APB and FPU stimulus against a reference model
// Inputs change and outputs are sampled on the falling edge
// FPU pulses and commits never overlap an APB access
//////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_csr_unit;

    localparam int CLK_PERIOD     = 4;
    localparam int TB_CORE_ID     = 3;
    localparam int TB_NUM_CORES   = 6;
    localparam int FIELD_WRITES   = 30;
    localparam int FLAG_ROUNDS    = 3;
    localparam int FLAG_CYCLES    = 24;
    localparam int COMMIT_ROUNDS  = 5;
    localparam int COMMIT_CYCLES  = 30;
    localparam int NUM_INFO       = 11;
    localparam int ACCESSES       = FIELD_WRITES * 2 + 12 + FLAG_ROUNDS * 4 + 4 * NUM_INFO + 20
                                    + COMMIT_ROUNDS * 5 + 12 + NUM_INFO + 4 + 2 + 4;
    localparam int TIMEOUT_CYCLES = ACCESSES * 6 + 200 + FLAG_ROUNDS * FLAG_CYCLES
                                    + COMMIT_ROUNDS * COMMIT_CYCLES;

    logic                                             clk;
    logic                                             reset;
    csr_pkg::apb_req_t                                apb_req;
    csr_pkg::apb_rsp_t                                apb_rsp;
    csr_pkg::fpu_flags_t [csr_pkg::NUM_FPU_PORTS-1:0] fpu_flags;
    csr_pkg::warp_id_t   [csr_pkg::NUM_FPU_PORTS-1:0] fpu_frm_wid;
    csr_pkg::frm_t       [csr_pkg::NUM_FPU_PORTS-1:0] fpu_frm;
    logic                                             commit;
    csr_pkg::thread_mask_t [csr_pkg::NUM_WARPS-1:0]   thread_masks;
    csr_pkg::warp_mask_t                              active_warps;

    // Reference model
    csr_pkg::fflags_t      model_fflags [csr_pkg::NUM_WARPS];
    csr_pkg::frm_t         model_frm [csr_pkg::NUM_WARPS];
    csr_pkg::thread_mask_t model_tmask [csr_pkg::NUM_WARPS];
    csr_pkg::warp_mask_t   model_awarps;
    longint unsigned       commit_count;
    int                    checks;
    int                    errors;

    csr_pkg::csr_addr_t info_addrs [NUM_INFO] = '{
        csr_pkg::CSR_MVENDORID, csr_pkg::CSR_MARCHID, csr_pkg::CSR_MIMPID, csr_pkg::CSR_MISA,
        csr_pkg::CSR_WARP_ID, csr_pkg::CSR_CORE_ID, csr_pkg::CSR_THREAD_MASK,
        csr_pkg::CSR_WARP_MASK, csr_pkg::CSR_NUM_THREADS, csr_pkg::CSR_NUM_WARPS,
        csr_pkg::CSR_NUM_CORES
    };
    csr_pkg::csr_addr_t counter_addrs [4] = '{
        csr_pkg::CSR_MCYCLE, csr_pkg::CSR_MCYCLE_H, csr_pkg::CSR_MINSTRET, csr_pkg::CSR_MINSTRET_H
    };
    csr_pkg::csr_addr_t placeholder_addrs [10] = '{
        csr_pkg::CSR_SATP, csr_pkg::CSR_MSTATUS, csr_pkg::CSR_MNSTATUS, csr_pkg::CSR_MEDELEG,
        csr_pkg::CSR_MIDELEG, csr_pkg::CSR_MIE, csr_pkg::CSR_MTVEC, csr_pkg::CSR_MEPC,
        csr_pkg::CSR_PMPCFG0, csr_pkg::CSR_PMPADDR0
    };
    csr_pkg::csr_addr_t unknown_addrs [6] = '{12'h000, 12'h004, 12'h7FF, 12'hB01, 12'hCC0, 12'hFFF};

    csr_unit #(
        .CORE_ID   (TB_CORE_ID),
        .NUM_CORES (TB_NUM_CORES)
    ) dut (
        .clk          (clk),
        .reset        (reset),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp),
        .fpu_flags    (fpu_flags),
        .fpu_frm_wid  (fpu_frm_wid),
        .fpu_frm      (fpu_frm),
        .commit       (commit),
        .thread_masks (thread_masks),
        .active_warps (active_warps)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [15:0] csr_address(input int wid, input csr_pkg::csr_addr_t a);
        return {2'b00, csr_pkg::warp_id_t'(wid), a};
    endfunction

    function automatic csr_pkg::csr_addr_t fp_addr(input int field);
        case (field)
            0:       return csr_pkg::CSR_FFLAGS;
            1:       return csr_pkg::CSR_FRM;
            default: return csr_pkg::CSR_FCSR;
        endcase
    endfunction

    // fcsr is frm above fflags
    function automatic csr_pkg::csr_data_t fp_expected(input int field, input int wid);
        case (field)
            0:       return {27'd0, model_fflags[wid]};
            1:       return {29'd0, model_frm[wid]};
            default: return {24'd0, model_frm[wid], model_fflags[wid]};
        endcase
    endfunction

    task automatic model_fp_write(input int field, input int wid, input csr_pkg::csr_data_t data);
        case (field)
            0: model_fflags[wid] = data[4:0];
            1: model_frm[wid] = data[2:0];
            default: begin
                model_fflags[wid] = data[4:0];
                model_frm[wid]    = data[7:5];
            end
        endcase
    endtask

    function automatic csr_pkg::csr_data_t info_expected(input csr_pkg::csr_addr_t a,
                                                         input int wid);
        case (a)
            csr_pkg::CSR_MVENDORID:   return csr_pkg::VENDOR_ID;
            csr_pkg::CSR_MARCHID:     return csr_pkg::ARCH_ID;
            csr_pkg::CSR_MIMPID:      return csr_pkg::IMPL_ID;
            csr_pkg::CSR_MISA:        return csr_pkg::MISA_VALUE;
            csr_pkg::CSR_WARP_ID:     return csr_pkg::csr_data_t'(wid);
            csr_pkg::CSR_CORE_ID:     return csr_pkg::csr_data_t'(TB_CORE_ID);
            csr_pkg::CSR_THREAD_MASK: return {28'd0, model_tmask[wid]};
            csr_pkg::CSR_WARP_MASK:   return {28'd0, model_awarps};
            csr_pkg::CSR_NUM_THREADS: return 32'd4;
            csr_pkg::CSR_NUM_WARPS:   return 32'd4;
            csr_pkg::CSR_NUM_CORES:   return csr_pkg::csr_data_t'(TB_NUM_CORES);
            default:                  return 32'd0;
        endcase
    endfunction

    task automatic access_check(input logic is_write, input logic [15:0] addr,
                                input csr_pkg::csr_data_t wdata, input logic exp_err,
                                input logic check_data, input csr_pkg::csr_data_t exp_data,
                                output csr_pkg::csr_data_t rdata);
        int   waited;
        logic err;
        waited = 0;
        @(negedge clk);
        apb_req.sel    = 1'b1;
        apb_req.enable = 1'b0;
        apb_req.write  = is_write;
        apb_req.addr   = addr;
        apb_req.wdata  = wdata;
        @(negedge clk);
        checks++;
        if (apb_rsp.ready) begin
            errors++;
            $display("[ERROR] %0t: ready high in the setup phase at address %h", $time, addr);
        end
        apb_req.enable = 1'b1;
        // Ready is due at the first falling edge after enable rises
        do begin
            @(negedge clk);
            waited++;
        end while (!apb_rsp.ready && waited < 8);
        rdata = apb_rsp.rdata;
        err   = apb_rsp.slverr;
        if (waited != 1) begin
            errors++;
            $display("[ERROR] %0t: ready after %0d falling edges at address %h, expected 1",
                     $time, waited, addr);
        end
        if (err !== exp_err) begin
            errors++;
            $display("[ERROR] %0t: slverr %b at address %h, expected %b", $time, err, addr, exp_err);
        end
        if (check_data && rdata !== exp_data) begin
            errors++;
            $display("[ERROR] %0t: read %h at address %h, expected %h",
                     $time, rdata, addr, exp_data);
        end
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic read_expect(input logic [15:0] addr, input csr_pkg::csr_data_t exp_data);
        csr_pkg::csr_data_t rdata;
        access_check(1'b0, addr, 32'd0, 1'b0, 1'b1, exp_data, rdata);
    endtask

    task automatic write_expect(input logic [15:0] addr, input csr_pkg::csr_data_t data,
                                input logic exp_err);
        csr_pkg::csr_data_t rdata;
        access_check(1'b1, addr, data, exp_err, 1'b0, 32'd0, rdata);
    endtask

    task automatic check_frm_ports();
        for (int p = 0; p < csr_pkg::NUM_FPU_PORTS; p++) begin
            checks++;
            if (fpu_frm[p] !== model_frm[fpu_frm_wid[p]]) begin
                errors++;
                $display("[ERROR] %0t: fpu_frm[%0d] is %0d for warp %0d, expected %0d",
                         $time, p, fpu_frm[p], fpu_frm_wid[p], model_frm[fpu_frm_wid[p]]);
            end
        end
    endtask

    // Watchdog
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        csr_pkg::csr_data_t rdata;
        csr_pkg::csr_data_t wdata;
        int                 wid;
        int                 field;
        longint unsigned    mcycle_prev;
        void'($urandom(82));
        reset        = 1'b1;
        apb_req      = '0;
        fpu_flags    = '0;
        fpu_frm_wid  = '0;
        commit       = 1'b0;
        thread_masks = '0;
        active_warps = '0;
        for (int w = 0; w < csr_pkg::NUM_WARPS; w++) begin
            model_fflags[w] = '0;
            model_frm[w]    = '0;
            model_tmask[w]  = '0;
        end
        model_awarps = '0;
        commit_count = 0;
        mcycle_prev  = 0;
        checks       = 0;
        errors       = 0;
        repeat (5) @(negedge clk);
        reset = 1'b0;

        // Random field writes and read-back of a random field
        for (int i = 0; i < FIELD_WRITES; i++) begin
            wid   = int'($urandom_range(0, csr_pkg::NUM_WARPS - 1));
            field = int'($urandom_range(0, 2));
            wdata = $urandom;
            write_expect(csr_address(wid, fp_addr(field)), wdata, 1'b0);
            model_fp_write(field, wid, wdata);
            field = int'($urandom_range(0, 2));
            read_expect(csr_address(wid, fp_addr(field)), fp_expected(field, wid));
        end
        for (int w = 0; w < csr_pkg::NUM_WARPS; w++) begin
            for (int f = 0; f < 3; f++) begin
                read_expect(csr_address(w, fp_addr(f)), fp_expected(f, w));
            end
        end

        // FPU flag pulses on both ports
        for (int r = 0; r < FLAG_ROUNDS; r++) begin
            for (int c = 0; c < FLAG_CYCLES; c++) begin
                @(negedge clk);
                check_frm_ports();
                for (int p = 0; p < csr_pkg::NUM_FPU_PORTS; p++) begin
                    fpu_flags[p].valid  = 1'($urandom_range(0, 1));
                    fpu_flags[p].wid    = csr_pkg::warp_id_t'($urandom);
                    fpu_flags[p].fflags = csr_pkg::fflags_t'($urandom);
                    fpu_frm_wid[p]      = csr_pkg::warp_id_t'($urandom);
                    if (fpu_flags[p].valid) begin
                        model_fflags[fpu_flags[p].wid] |= fpu_flags[p].fflags;
                    end
                end
            end
            @(negedge clk);
            check_frm_ports();
            fpu_flags = '0;
            for (int w = 0; w < csr_pkg::NUM_WARPS; w++) begin
                read_expect(csr_address(w, csr_pkg::CSR_FFLAGS), fp_expected(0, w));
            end
        end

        // Information CSRs with fresh status inputs per warp
        for (int w = 0; w < csr_pkg::NUM_WARPS; w++) begin
            @(negedge clk);
            for (int t = 0; t < csr_pkg::NUM_WARPS; t++) begin
                model_tmask[t]  = csr_pkg::thread_mask_t'($urandom);
                thread_masks[t] = model_tmask[t];
            end
            model_awarps = csr_pkg::warp_mask_t'($urandom);
            active_warps = model_awarps;
            for (int i = 0; i < NUM_INFO; i++) begin
                read_expect(csr_address(w, info_addrs[i]), info_expected(info_addrs[i], w));
            end
        end

        for (int i = 0; i < 10; i++) begin
            wid = int'($urandom_range(0, csr_pkg::NUM_WARPS - 1));
            write_expect(csr_address(wid, placeholder_addrs[i]), $urandom, 1'b0);
            read_expect(csr_address(wid, placeholder_addrs[i]), 32'd0);
        end

        // Commit bursts followed by counter reads with commit low
        for (int r = 0; r < COMMIT_ROUNDS; r++) begin
            for (int c = 0; c < COMMIT_CYCLES; c++) begin
                @(negedge clk);
                commit = 1'($urandom_range(0, 1));
                if (commit) begin
                    commit_count++;
                end
            end
            @(negedge clk);
            commit = 1'b0;
            read_expect(csr_address(0, csr_pkg::CSR_MINSTRET), csr_pkg::csr_data_t'(commit_count));
            read_expect(csr_address(0, csr_pkg::CSR_MINSTRET_H),
                        csr_pkg::csr_data_t'(commit_count >> 32));
            // High half stays zero over a short run
            read_expect(csr_address(0, csr_pkg::CSR_MCYCLE_H), 32'd0);
            for (int k = 0; k < 2; k++) begin
                access_check(1'b0, csr_address(0, csr_pkg::CSR_MCYCLE), 32'd0, 1'b0, 1'b0,
                             32'd0, rdata);
                checks++;
                if (64'(rdata) < mcycle_prev + 3) begin
                    errors++;
                    $display("[ERROR] %0t: mcycle read %0d after %0d, expected a rise of 3 or more",
                             $time, rdata, mcycle_prev);
                end
                mcycle_prev = 64'(rdata);
            end
        end

        // Error responses leave the fp state untouched
        for (int i = 0; i < 6; i++) begin
            wid = int'($urandom_range(0, csr_pkg::NUM_WARPS - 1));
            access_check(1'b0, csr_address(wid, unknown_addrs[i]), 32'd0, 1'b1, 1'b0, 32'd0, rdata);
            write_expect(csr_address(wid, unknown_addrs[i]), $urandom, 1'b1);
        end
        for (int i = 0; i < NUM_INFO; i++) begin
            write_expect(csr_address(i % 4, info_addrs[i]), $urandom, 1'b1);
        end
        for (int i = 0; i < 4; i++) begin
            write_expect(csr_address(i, counter_addrs[i]), $urandom, 1'b1);
        end
        write_expect({2'b01, 2'd0, csr_pkg::CSR_FCSR}, $urandom, 1'b1);
        write_expect({2'b10, 2'd1, csr_pkg::CSR_FFLAGS}, $urandom, 1'b1);
        for (int w = 0; w < csr_pkg::NUM_WARPS; w++) begin
            read_expect(csr_address(w, csr_pkg::CSR_FCSR), fp_expected(2, w));
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* source/csr_unit.sv */
//////////////////////////////////////////////////
// CSR block of one compute core behind an APB port
// CORE_ID and NUM_CORES only feed the info CSRs
//////////////////////////////////////////////////

`timescale 1ns/1ns

module csr_unit #(
    parameter int CORE_ID   = 0,
    parameter int NUM_CORES = 1
) (
    input  logic                                              clk,
    input  logic                                              reset,
    input  csr_pkg::apb_req_t                                 apb_req,
    output csr_pkg::apb_rsp_t                                 apb_rsp,
    input  csr_pkg::fpu_flags_t [csr_pkg::NUM_FPU_PORTS-1:0]  fpu_flags,
    input  csr_pkg::warp_id_t   [csr_pkg::NUM_FPU_PORTS-1:0]  fpu_frm_wid,
    output csr_pkg::frm_t       [csr_pkg::NUM_FPU_PORTS-1:0]  fpu_frm,
    input  logic                                              commit,
    input  csr_pkg::thread_mask_t [csr_pkg::NUM_WARPS-1:0]    thread_masks,
    input  csr_pkg::warp_mask_t                               active_warps
);

    csr_pkg::fcsr_write_t fcsr_wr;
    csr_pkg::csr_addr_t   csr_addr;
    csr_pkg::warp_id_t    csr_wid;
    csr_pkg::fcsr_t       fcsr_rdata;
    csr_pkg::csr_data_t   info_rdata;
    logic                 info_hit;

    csr_apb_slave u_apb_slave (
        .clk        (clk),
        .reset      (reset),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .fcsr_wr    (fcsr_wr),
        .csr_addr   (csr_addr),
        .csr_wid    (csr_wid),
        .fcsr_rdata (fcsr_rdata),
        .info_rdata (info_rdata),
        .info_hit   (info_hit)
    );

    fcsr_file u_fcsr_file (
        .clk         (clk),
        .reset       (reset),
        .fcsr_wr     (fcsr_wr),
        .fpu_flags   (fpu_flags),
        .fpu_frm_wid (fpu_frm_wid),
        .fpu_frm     (fpu_frm),
        .read_wid    (csr_wid),
        .read_fcsr   (fcsr_rdata)
    );

    core_info_csrs #(
        .CORE_ID   (CORE_ID),
        .NUM_CORES (NUM_CORES)
    ) u_core_info (
        .clk          (clk),
        .reset        (reset),
        .commit       (commit),
        .thread_masks (thread_masks),
        .active_warps (active_warps),
        .read_addr    (csr_addr),
        .read_wid     (csr_wid),
        .read_data    (info_rdata),
        .read_hit     (info_hit)
    );

endmodule

/* source/csr_apb_slave.sv */
//////////////////////////////////////////////////
// APB slave with one wait state per access
// Read data and error are sampled in the first access
// cycle; an fcsr write is issued in the ready cycle
// Address bits 15:14 must be zero or the access errors
//////////////////////////////////////////////////

`timescale 1ns/1ns

module csr_apb_slave (
    input  logic                  clk,
    input  logic                  reset,
    input  csr_pkg::apb_req_t     apb_req,
    output csr_pkg::apb_rsp_t     apb_rsp,
    output csr_pkg::fcsr_write_t  fcsr_wr,
    output csr_pkg::csr_addr_t    csr_addr,
    output csr_pkg::warp_id_t     csr_wid,
    input  csr_pkg::fcsr_t        fcsr_rdata,
    input  csr_pkg::csr_data_t    info_rdata,
    input  logic                  info_hit
);

    csr_pkg::apb_state_e  state_q;
    csr_pkg::apb_state_e  state_n;
    csr_pkg::csr_data_t   rdata_q;
    csr_pkg::csr_data_t   read_value;
    csr_pkg::fcsr_field_e fp_field;
    logic                 err_q;
    logic                 is_fp;
    logic                 is_placeholder;
    logic                 addr_ok;
    logic                 access_err;

    assign csr_addr = apb_req.addr[11:0];
    assign csr_wid  = apb_req.addr[13:12];
    assign addr_ok  = (apb_req.addr[15:14] == 2'b00);

    // Address classes
    always_comb begin
        is_fp          = 1'b1;
        is_placeholder = 1'b0;
        fp_field       = csr_pkg::FIELD_FCSR;
        read_value     = '0;
        case (csr_addr)
            csr_pkg::CSR_FFLAGS: begin
                fp_field   = csr_pkg::FIELD_FFLAGS;
                read_value = 32'(fcsr_rdata[csr_pkg::FFLAGS_BITS-1:0]);
            end
            csr_pkg::CSR_FRM: begin
                fp_field   = csr_pkg::FIELD_FRM;
                read_value = 32'(fcsr_rdata[csr_pkg::FRM_BITS+csr_pkg::FFLAGS_BITS-1:
                                            csr_pkg::FFLAGS_BITS]);
            end
            csr_pkg::CSR_FCSR: begin
                read_value = 32'(fcsr_rdata);
            end
            csr_pkg::CSR_SATP,
            csr_pkg::CSR_MSTATUS,
            csr_pkg::CSR_MNSTATUS,
            csr_pkg::CSR_MEDELEG,
            csr_pkg::CSR_MIDELEG,
            csr_pkg::CSR_MIE,
            csr_pkg::CSR_MTVEC,
            csr_pkg::CSR_MEPC,
            csr_pkg::CSR_PMPCFG0,
            csr_pkg::CSR_PMPADDR0: begin
                is_fp          = 1'b0;
                is_placeholder = 1'b1;
            end
            default: begin
                is_fp      = 1'b0;
                read_value = info_rdata;
            end
        endcase
    end

    // Unknown address, or a write to a read-only CSR
    assign access_err = !addr_ok || !(is_fp || is_placeholder || info_hit)
                        || (apb_req.write && info_hit);

    always_comb begin
        state_n = state_q;
        case (state_q)
            csr_pkg::IDLE: begin
                if (apb_req.sel && !apb_req.enable) begin
                    state_n = csr_pkg::SETUP_WAIT;
                end
            end
            csr_pkg::SETUP_WAIT: begin
                if (apb_req.sel && apb_req.enable) begin
                    state_n = csr_pkg::RESPOND;
                end else if (!apb_req.sel) begin
                    state_n = csr_pkg::IDLE;
                end
            end
            default: begin
                state_n = csr_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= csr_pkg::IDLE;
            err_q   <= 1'b0;
        end else begin
            state_q <= state_n;
            if (state_q == csr_pkg::SETUP_WAIT && state_n == csr_pkg::RESPOND) begin
                err_q <= access_err;
            end
        end
    end

    // Sampled at the end of the first access cycle
    always_ff @(posedge clk) begin
        if (state_q == csr_pkg::SETUP_WAIT && state_n == csr_pkg::RESPOND) begin
            rdata_q <= access_err ? '0 : read_value;
        end
    end

    assign apb_rsp.ready  = (state_q == csr_pkg::RESPOND);
    assign apb_rsp.rdata  = rdata_q;
    assign apb_rsp.slverr = (state_q == csr_pkg::RESPOND) && err_q;

    // Write lands at the edge that ends the ready cycle
    assign fcsr_wr.valid = (state_q == csr_pkg::RESPOND) && apb_req.write && is_fp && addr_ok;
    assign fcsr_wr.wid   = csr_wid;
    assign fcsr_wr.field = fp_field;
    assign fcsr_wr.data  = apb_req.wdata;

endmodule

/* source/core_info_csrs.sv */
//////////////////////////////////////////////////
// Read-only core information and the 64-bit counters
// mcycle counts every clock out of reset, minstret
// counts commit pulses; read_hit flags a known CSR
//////////////////////////////////////////////////

`timescale 1ns/1ns

module core_info_csrs #(
    parameter int CORE_ID   = 0,
    parameter int NUM_CORES = 1
) (
    input  logic                                               clk,
    input  logic                                               reset,
    input  logic                                               commit,
    input  csr_pkg::thread_mask_t [csr_pkg::NUM_WARPS-1:0]     thread_masks,
    input  csr_pkg::warp_mask_t                                active_warps,
    input  csr_pkg::csr_addr_t                                 read_addr,
    input  csr_pkg::warp_id_t                                  read_wid,
    output csr_pkg::csr_data_t                                 read_data,
    output logic                                               read_hit
);

    csr_pkg::perf_ctr_t mcycle_q;
    csr_pkg::perf_ctr_t minstret_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            mcycle_q   <= '0;
            minstret_q <= '0;
        end else begin
            mcycle_q <= mcycle_q + 64'd1;
            if (commit) begin
                minstret_q <= minstret_q + 64'd1;
            end
        end
    end

    always_comb begin
        read_data = '0;
        read_hit  = 1'b1;
        case (read_addr)
            csr_pkg::CSR_MVENDORID:   read_data = csr_pkg::VENDOR_ID;
            csr_pkg::CSR_MARCHID:     read_data = csr_pkg::ARCH_ID;
            csr_pkg::CSR_MIMPID:      read_data = csr_pkg::IMPL_ID;
            csr_pkg::CSR_MISA:        read_data = csr_pkg::MISA_VALUE;
            csr_pkg::CSR_WARP_ID:     read_data = 32'(read_wid);
            csr_pkg::CSR_CORE_ID:     read_data = 32'(CORE_ID);
            csr_pkg::CSR_THREAD_MASK: read_data = 32'(thread_masks[read_wid]);
            csr_pkg::CSR_WARP_MASK:   read_data = 32'(active_warps);
            csr_pkg::CSR_NUM_THREADS: read_data = 32'(csr_pkg::NUM_THREADS);
            csr_pkg::CSR_NUM_WARPS:   read_data = 32'(csr_pkg::NUM_WARPS);
            csr_pkg::CSR_NUM_CORES:   read_data = 32'(NUM_CORES);
            // Counter halves
            csr_pkg::CSR_MCYCLE:      read_data = mcycle_q[31:0];
            csr_pkg::CSR_MCYCLE_H:    read_data = mcycle_q[63:32];
            csr_pkg::CSR_MINSTRET:    read_data = minstret_q[31:0];
            csr_pkg::CSR_MINSTRET_H:  read_data = minstret_q[63:32];
            default: begin
                read_hit = 1'b0;
            end
        endcase
    end

endmodule

/* source/fcsr_file.sv */
//////////////////////////////////////////////////
// Per-warp fflags and frm storage
// FPU flags OR in each cycle and a CSR write on the
// same warp and field overrides them
//////////////////////////////////////////////////

`timescale 1ns/1ns

module fcsr_file (
    input  logic                                              clk,
    input  logic                                              reset,
    input  csr_pkg::fcsr_write_t                              fcsr_wr,
    input  csr_pkg::fpu_flags_t [csr_pkg::NUM_FPU_PORTS-1:0]  fpu_flags,
    input  csr_pkg::warp_id_t   [csr_pkg::NUM_FPU_PORTS-1:0]  fpu_frm_wid,
    output csr_pkg::frm_t       [csr_pkg::NUM_FPU_PORTS-1:0]  fpu_frm,
    input  csr_pkg::warp_id_t                                 read_wid,
    output csr_pkg::fcsr_t                                    read_fcsr
);

    csr_pkg::fflags_t [csr_pkg::NUM_WARPS-1:0] fflags_q;
    csr_pkg::fflags_t [csr_pkg::NUM_WARPS-1:0] fflags_n;
    csr_pkg::frm_t    [csr_pkg::NUM_WARPS-1:0] frm_q;
    csr_pkg::frm_t    [csr_pkg::NUM_WARPS-1:0] frm_n;

    always_comb begin
        fflags_n = fflags_q;
        frm_n    = frm_q;

        // Exception flags from every valid FPU port
        for (int i = 0; i < csr_pkg::NUM_FPU_PORTS; i++) begin
            if (fpu_flags[i].valid) begin
                fflags_n[fpu_flags[i].wid] = fflags_n[fpu_flags[i].wid] | fpu_flags[i].fflags;
            end
        end

        // Software write applied last so it wins
        if (fcsr_wr.valid) begin
            case (fcsr_wr.field)
                csr_pkg::FIELD_FFLAGS: begin
                    fflags_n[fcsr_wr.wid] = fcsr_wr.data[csr_pkg::FFLAGS_BITS-1:0];
                end
                csr_pkg::FIELD_FRM: begin
                    frm_n[fcsr_wr.wid] = fcsr_wr.data[csr_pkg::FRM_BITS-1:0];
                end
                csr_pkg::FIELD_FCSR: begin
                    fflags_n[fcsr_wr.wid] = fcsr_wr.data[csr_pkg::FFLAGS_BITS-1:0];
                    frm_n[fcsr_wr.wid] =
                        fcsr_wr.data[csr_pkg::FRM_BITS+csr_pkg::FFLAGS_BITS-1:csr_pkg::FFLAGS_BITS];
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fflags_q <= '0;
            frm_q    <= '0;
        end else begin
            fflags_q <= fflags_n;
            frm_q    <= frm_n;
        end
    end

    // Rounding mode lookup per FPU port
    always_comb begin
        for (int i = 0; i < csr_pkg::NUM_FPU_PORTS; i++) begin
            fpu_frm[i] = frm_q[fpu_frm_wid[i]];
        end
    end

    assign read_fcsr = {frm_q[read_wid], fflags_q[read_wid]};

endmodule

/* source/csr_pkg.sv */
//////////////////////////////////////////////////
// Shared widths, CSR map and bus types of the CSR block
// Four warps of four threads, two FPU ports
// APB address bits 13:12 carry the warp, 11:0 the CSR
//////////////////////////////////////////////////

package csr_pkg;

    localparam int WID_BITS      = 2;
    localparam int NUM_WARPS     = 4;
    localparam int NUM_THREADS   = 4;
    localparam int NUM_FPU_PORTS = 2;
    localparam int FFLAGS_BITS   = 5;
    localparam int FRM_BITS      = 3;

    typedef logic [WID_BITS-1:0]             warp_id_t;
    typedef logic [NUM_THREADS-1:0]          thread_mask_t;
    typedef logic [NUM_WARPS-1:0]            warp_mask_t;
    typedef logic [FFLAGS_BITS-1:0]          fflags_t;
    typedef logic [FRM_BITS-1:0]             frm_t;
    typedef logic [FRM_BITS+FFLAGS_BITS-1:0] fcsr_t;
    typedef logic [11:0]                     csr_addr_t;
    typedef logic [31:0]                     csr_data_t;
    typedef logic [63:0]                     perf_ctr_t;
    typedef logic [15:0]                     apb_addr_t;

    // Floating-point CSRs, one set per warp
    localparam csr_addr_t CSR_FFLAGS      = 12'h001;
    localparam csr_addr_t CSR_FRM         = 12'h002;
    localparam csr_addr_t CSR_FCSR        = 12'h003;

    // Placeholders, writes dropped and reads zero
    localparam csr_addr_t CSR_SATP        = 12'h180;
    localparam csr_addr_t CSR_MSTATUS     = 12'h300;
    localparam csr_addr_t CSR_MEDELEG     = 12'h302;
    localparam csr_addr_t CSR_MIDELEG     = 12'h303;
    localparam csr_addr_t CSR_MIE         = 12'h304;
    localparam csr_addr_t CSR_MTVEC       = 12'h305;
    localparam csr_addr_t CSR_MEPC        = 12'h341;
    localparam csr_addr_t CSR_PMPCFG0     = 12'h3A0;
    localparam csr_addr_t CSR_PMPADDR0    = 12'h3B0;
    localparam csr_addr_t CSR_MNSTATUS    = 12'h744;

    // Read-only machine information and counters
    localparam csr_addr_t CSR_MISA        = 12'h301;
    localparam csr_addr_t CSR_MCYCLE      = 12'hB00;
    localparam csr_addr_t CSR_MINSTRET    = 12'hB02;
    localparam csr_addr_t CSR_MCYCLE_H    = 12'hB80;
    localparam csr_addr_t CSR_MINSTRET_H  = 12'hB82;
    localparam csr_addr_t CSR_MVENDORID   = 12'hF11;
    localparam csr_addr_t CSR_MARCHID     = 12'hF12;
    localparam csr_addr_t CSR_MIMPID      = 12'hF13;

    // Core-specific, custom read-only space
    localparam csr_addr_t CSR_WARP_ID     = 12'hCC1;
    localparam csr_addr_t CSR_CORE_ID     = 12'hCC2;
    localparam csr_addr_t CSR_WARP_MASK   = 12'hCC3;
    localparam csr_addr_t CSR_THREAD_MASK = 12'hCC4;
    localparam csr_addr_t CSR_NUM_THREADS = 12'hFC0;
    localparam csr_addr_t CSR_NUM_WARPS   = 12'hFC1;
    localparam csr_addr_t CSR_NUM_CORES   = 12'hFC2;

    localparam csr_data_t VENDOR_ID  = 32'h0000_0000;
    localparam csr_data_t ARCH_ID    = 32'h0000_0002;
    localparam csr_data_t IMPL_ID    = 32'h0000_0001;
    // RV32 with I, M and F
    localparam csr_data_t MISA_VALUE = 32'h4000_1120;

    typedef enum logic [1:0] {FIELD_FFLAGS, FIELD_FRM, FIELD_FCSR} fcsr_field_e;
    typedef enum logic [1:0] {IDLE, SETUP_WAIT, RESPOND} apb_state_e;

    typedef struct packed {
        logic      sel;
        logic      enable;
        logic      write;
        apb_addr_t addr;
        csr_data_t wdata;
    } apb_req_t;

    typedef struct packed {
        logic      ready;
        csr_data_t rdata;
        logic      slverr;
    } apb_rsp_t;

    typedef struct packed {
        logic     valid;
        warp_id_t wid;
        fflags_t  fflags;
    } fpu_flags_t;

    typedef struct packed {
        logic        valid;
        warp_id_t    wid;
        fcsr_field_e field;
        csr_data_t   data;
    } fcsr_write_t;

endpackage
